//--- rtl/wbuf_pkg.sv
/*
 * write buffer shared definitions
 * word width, depth, pointer and count widths,
 * and the request and status structs passed between stages
 */
package wbuf_pkg;

   // buffered word and storage geometry
   localparam int unsigned data_w = 64;
   localparam int unsigned depth  = 4;
   localparam int unsigned ptr_w  = 2;
   // holds 0 through depth
   localparam int unsigned cnt_w  = 3;

   // registered request from the capture stage
   typedef struct packed {
      logic              push;
      logic              pop;
      logic [data_w-1:0] data;
   } wbuf_req_t;

   // buffer status, all fields registered in control
   typedef struct packed {
      logic             empty;
      logic             full;
      logic [cnt_w-1:0] count;
      logic             err;
   } wbuf_stat_t;

endpackage

//--- rtl/wbuf_capture.sv
/*
 * write buffer capture stage
 * registers the push and pop strobes every cycle and
 * holds the most recently pushed word for storage
 */
module wbuf_capture (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          push,
   input  logic                          pop,
   input  logic [wbuf_pkg::data_w-1:0]   data_in,
   output wbuf_pkg::wbuf_req_t           req
);

   // strobes are sampled unconditionally, one request per cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req.push <= 1'b0;
         req.pop  <= 1'b0;
      end else begin
         req.push <= push;
         req.pop  <= pop;
      end
   end

   // data only moves on a push
   // keeps the word steady for the storage write that follows
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req.data <= '0;
      end else if (push) begin
         req.data <= data_in;
      end
   end

endmodule

//--- rtl/wbuf_ctrl.sv
/*
 * write buffer control
 * accepts or rejects each registered request, moves the
 * read and write pointers, and keeps count, flags and err
 */
module wbuf_ctrl (
   input  logic                          clk,
   input  logic                          rst_n,
   input  wbuf_pkg::wbuf_req_t           req,
   output logic                          wr_en,
   output logic [wbuf_pkg::ptr_w-1:0]    wr_ptr,
   output logic [wbuf_pkg::ptr_w-1:0]    rd_ptr,
   output wbuf_pkg::wbuf_stat_t          stat
);

   logic                         push_ok;
   logic                         pop_ok;
   logic                         err_d;
   logic [wbuf_pkg::cnt_w-1:0]   count_d;
   logic                         empty_d;
   logic                         full_d;

   // acceptance
   // a pop needs a word, a push needs room or a pop in the same request
   always_comb begin
      pop_ok  = req.pop && !stat.empty;
      push_ok = req.push && (!stat.full || pop_ok);
      err_d   = (req.push && !push_ok) || (req.pop && !pop_ok);
   end

   // next occupancy
   always_comb begin
      unique case ({push_ok, pop_ok})
         2'b10:   count_d = stat.count + 1'b1;
         2'b01:   count_d = stat.count - 1'b1;
         default: count_d = stat.count;
      endcase
   end

   // flags move only on a net push or a net pop
   always_comb begin
      empty_d = stat.empty;
      full_d  = stat.full;
      if (push_ok && !pop_ok) begin
         empty_d = 1'b0;
         full_d  = (stat.count == wbuf_pkg::cnt_w'(wbuf_pkg::depth - 1));
      end else if (pop_ok && !push_ok) begin
         full_d  = 1'b0;
         empty_d = (stat.count == wbuf_pkg::cnt_w'(1));
      end
   end

   // storage writes on the same edge the write pointer moves
   assign wr_en = push_ok;

   // pointers wrap naturally at depth 4
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // status register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stat.empty <= 1'b1;
         stat.full  <= 1'b0;
         stat.count <= '0;
         stat.err   <= 1'b0;
      end else begin
         stat.empty <= empty_d;
         stat.full  <= full_d;
         stat.count <= count_d;
         // one cycle pulse per rejected request
         stat.err   <= err_d;
      end
   end

   a_count_max: assert property (
      @(posedge clk) disable iff (!rst_n)
      stat.count <= wbuf_pkg::cnt_w'(wbuf_pkg::depth)
   ) else $error("wbuf_ctrl: count %0d above depth", stat.count);

   a_flags_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(stat.empty && stat.full)
   ) else $error("wbuf_ctrl: empty and full both set");

   a_empty_count: assert property (
      @(posedge clk) disable iff (!rst_n)
      stat.empty == (stat.count == '0)
   ) else $error("wbuf_ctrl: empty flag disagrees with count %0d", stat.count);

endmodule

//--- rtl/wbuf_store.sv
/*
 * write buffer storage
 * four entry registers loaded through a decoded write
 * enable and read through a mux on the read pointer
 */
module wbuf_store (
   input  logic                          clk,
   input  logic                          rst_n,
   input  wbuf_pkg::wbuf_req_t           req,
   input  logic                          wr_en,
   input  logic [wbuf_pkg::ptr_w-1:0]    wr_ptr,
   input  logic [wbuf_pkg::ptr_w-1:0]    rd_ptr,
   output logic [wbuf_pkg::data_w-1:0]   data_out
);

   logic [wbuf_pkg::depth-1:0]    wr_sel;
   logic [wbuf_pkg::data_w-1:0]   entry [wbuf_pkg::depth];

   // one hot write select, all zero without an accepted push
   always_comb begin
      wr_sel = '0;
      wr_sel[wr_ptr] = wr_en;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < wbuf_pkg::depth; i++) begin
            entry[i] <= '0;
         end
      end else begin
         for (int i = 0; i < wbuf_pkg::depth; i++) begin
            if (wr_sel[i]) begin
               entry[i] <= req.data;
            end
         end
      end
   end

   // head word, stale while the buffer is empty
   assign data_out = entry[rd_ptr];

endmodule

//--- rtl/wbuf_top.sv
/*
 * write buffer top level
 * capture, control and storage in a two cycle pipeline
 * from request strobes to status and head word
 */
module wbuf_top (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          push,
   input  logic                          pop,
   input  logic [wbuf_pkg::data_w-1:0]   data_in,
   output wbuf_pkg::wbuf_stat_t          stat,
   output logic [wbuf_pkg::data_w-1:0]   data_out
);

   wbuf_pkg::wbuf_req_t              req;
   logic                             wr_en;
   logic [wbuf_pkg::ptr_w-1:0]       wr_ptr;
   logic [wbuf_pkg::ptr_w-1:0]       rd_ptr;

   wbuf_capture u_capture (
      .clk     (clk),
      .rst_n   (rst_n),
      .push    (push),
      .pop     (pop),
      .data_in (data_in),
      .req     (req)
   );

   wbuf_ctrl u_ctrl (
      .clk     (clk),
      .rst_n   (rst_n),
      .req     (req),
      .wr_en   (wr_en),
      .wr_ptr  (wr_ptr),
      .rd_ptr  (rd_ptr),
      .stat    (stat)
   );

   wbuf_store u_store (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .wr_en    (wr_en),
      .wr_ptr   (wr_ptr),
      .rd_ptr   (rd_ptr),
      .data_out (data_out)
   );

endmodule

//--- dv/wbuf_tb.sv
/*
 * write buffer testbench
 * applies per-cycle vectors from a file to the top level
 * and checks status and head word two cycles later
 */
module wbuf_tb;

   timeunit 1ns;
   timeprecision 100ps;

   logic                          clk;
   logic                          rst_n;
   logic                          push;
   logic                          pop;
   logic [wbuf_pkg::data_w-1:0]   data_in;
   wbuf_pkg::wbuf_stat_t          stat;
   logic [wbuf_pkg::data_w-1:0]   data_out;

   // vector columns, one entry per stimulus line
   int                            v_test  [$];
   logic                          v_push  [$];
   logic                          v_pop   [$];
   logic [wbuf_pkg::data_w-1:0]   v_data  [$];
   int                            v_empty [$];
   int                            v_full  [$];
   int                            v_count [$];
   int                            v_err   [$];
   logic [wbuf_pkg::data_w-1:0]   v_head  [$];

   int   n_vec;
   int   checks;
   int   errors;
   int   tests_done;
   int   cur_test;
   int   test_checks;
   int   test_errs;
   int   cycles;
   // reset plus margin until the vectors are loaded
   int   cycle_limit;
   logic load_ok;

   wbuf_top i_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (push),
      .pop      (pop),
      .data_in  (data_in),
      .stat     (stat),
      .data_out (data_out)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("simulation timed out after %0d cycles", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   task automatic load_vectors();
      int          fd;
      int          code;
      int          t;
      int          ps;
      int          pp;
      int          e;
      int          f;
      int          c;
      int          er;
      logic [63:0] d;
      logic [63:0] h;
      string       line;
      load_ok = 1'b0;
      fd = $fopen("dv/wbuf_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file dv/wbuf_stimulus.txt");
      end else begin
         load_ok = 1'b1;
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            // skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            code = $sscanf(line, "%d %d %d %h %d %d %d %d %h", t, ps, pp, d, e, f, c, er, h);
            if (code == 9) begin
               v_test.push_back(t);
               v_push.push_back(ps[0]);
               v_pop.push_back(pp[0]);
               v_data.push_back(d);
               v_empty.push_back(e);
               v_full.push_back(f);
               v_count.push_back(c);
               v_err.push_back(er);
               v_head.push_back(h);
            end else begin
               $display("malformed vector line: %s", line);
               errors++;
            end
         end
         $fclose(fd);
         n_vec = v_test.size();
         cycle_limit = n_vec + 10 + 20;
      end
   endtask

   task automatic compare_field(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
      checks++;
      test_checks++;
      assert (act === exp) else begin
         $display("MISMATCH at %0t ns: %s expected %0h, actual %0h", $time, name, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic close_test();
      $display("test %0d %s, %0d checks, %0d errors", cur_test,
               (test_errs == 0) ? "ok" : "FAILED", test_checks, test_errs);
      tests_done++;
   endtask

   task automatic check_vector(input int j);
      if (v_test[j] != cur_test) begin
         if (cur_test >= 0) close_test();
         cur_test    = v_test[j];
         test_checks = 0;
         test_errs   = 0;
      end
      compare_field("empty", 64'(v_empty[j]), 64'(stat.empty));
      compare_field("full", 64'(v_full[j]), 64'(stat.full));
      compare_field("count", 64'(v_count[j]), 64'(stat.count));
      compare_field("err", 64'(v_err[j]), 64'(stat.err));
      // head word means nothing while empty
      if (v_empty[j] == 0) begin
         compare_field("data_out", v_head[j], data_out);
      end
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      push        = 1'b0;
      pop         = 1'b0;
      data_in     = '0;
      n_vec       = 0;
      checks      = 0;
      errors      = 0;
      tests_done  = 0;
      cur_test    = -1;
      test_checks = 0;
      test_errs   = 0;
      cycles      = 0;
      cycle_limit = 10 + 20;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      load_vectors();
      if (!load_ok) begin
         $display("Test failures found");
         $finish;
      end else begin
         // line k is driven at edge k and its result is seen after edge k+2
         for (int k = 0; k < n_vec + 2; k++) begin
            @(posedge clk);
            if (k < n_vec) begin
               push    <= v_push[k];
               pop     <= v_pop[k];
               data_in <= v_data[k];
            end else begin
               push    <= 1'b0;
               pop     <= 1'b0;
               data_in <= '0;
            end
            @(negedge clk);
            if (k >= 2) check_vector(k - 2);
         end
         if (cur_test >= 0) close_test();
         $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
         if (errors == 0 && checks > 0) begin
            $display("All tests passed!");
         end else begin
            $display("Test failures found");
         end
         $finish;
      end
   end

endmodule

//--- dv/wbuf_stimulus.txt
# test push pop data_in | exp_empty exp_full exp_count exp_err exp_data_out
# one line per cycle, data in hex, exp_data_out ignored while exp_empty is 1
1 0 0 0000000000000000 1 0 0 0 0000000000000000
1 0 0 0000000000000000 1 0 0 0 0000000000000000
1 0 0 0000000000000000 1 0 0 0 0000000000000000
2 1 0 1000000000000001 0 0 1 0 1000000000000001
2 1 0 2000000000000002 0 0 2 0 1000000000000001
2 1 0 3000000000000003 0 0 3 0 1000000000000001
2 1 0 4000000000000004 0 1 4 0 1000000000000001
2 0 1 ffffffffffffffff 0 0 3 0 2000000000000002
2 0 1 0000000000000000 0 0 2 0 3000000000000003
2 0 1 0000000000000000 0 0 1 0 4000000000000004
2 0 1 0000000000000000 1 0 0 0 0000000000000000
2 0 0 0000000000000000 1 0 0 0 0000000000000000
3 1 0 5000000000000005 0 0 1 0 5000000000000005
3 1 0 6000000000000006 0 0 2 0 5000000000000005
3 1 0 7000000000000007 0 0 3 0 5000000000000005
3 1 0 8000000000000008 0 1 4 0 5000000000000005
3 1 0 deadbeefdeadbeef 0 1 4 1 5000000000000005
3 0 0 0000000000000000 0 1 4 0 5000000000000005
3 0 1 0000000000000000 0 0 3 0 6000000000000006
3 0 1 0000000000000000 0 0 2 0 7000000000000007
3 0 1 0000000000000000 0 0 1 0 8000000000000008
3 0 1 0000000000000000 1 0 0 0 0000000000000000
4 0 1 0000000000000000 1 0 0 1 0000000000000000
4 0 0 0000000000000000 1 0 0 0 0000000000000000
4 0 1 0000000000000000 1 0 0 1 0000000000000000
4 0 1 0000000000000000 1 0 0 1 0000000000000000
4 0 0 0000000000000000 1 0 0 0 0000000000000000
5 1 0 9000000000000009 0 0 1 0 9000000000000009
5 1 0 a00000000000000a 0 0 2 0 9000000000000009
5 1 1 b00000000000000b 0 0 2 0 a00000000000000a
5 1 1 c00000000000000c 0 0 2 0 b00000000000000b
5 1 0 d00000000000000d 0 0 3 0 b00000000000000b
5 1 0 e00000000000000e 0 1 4 0 b00000000000000b
5 1 1 f00000000000000f 0 1 4 0 c00000000000000c
5 0 1 0000000000000000 0 0 3 0 d00000000000000d
5 0 1 0000000000000000 0 0 2 0 e00000000000000e
5 0 1 0000000000000000 0 0 1 0 f00000000000000f
5 0 1 0000000000000000 1 0 0 0 0000000000000000
5 1 1 0123456789abcdef 0 0 1 1 0123456789abcdef
5 0 0 0000000000000000 0 0 1 0 0123456789abcdef
5 0 1 0000000000000000 1 0 0 0 0000000000000000
6 1 0 5a5a5a5a00000001 0 0 1 0 5a5a5a5a00000001
6 1 0 5a5a5a5a00000002 0 0 2 0 5a5a5a5a00000001
6 1 0 5a5a5a5a00000003 0 0 3 0 5a5a5a5a00000001
6 0 1 0000000000000000 0 0 2 0 5a5a5a5a00000002
6 1 0 5a5a5a5a00000004 0 0 3 0 5a5a5a5a00000002
6 0 1 0000000000000000 0 0 2 0 5a5a5a5a00000003
6 1 1 5a5a5a5a00000005 0 0 2 0 5a5a5a5a00000004
6 1 0 5a5a5a5a00000006 0 0 3 0 5a5a5a5a00000004
6 0 1 0000000000000000 0 0 2 0 5a5a5a5a00000005
6 1 1 5a5a5a5a00000007 0 0 2 0 5a5a5a5a00000006
6 1 0 5a5a5a5a00000008 0 0 3 0 5a5a5a5a00000006
6 1 0 5a5a5a5a00000009 0 1 4 0 5a5a5a5a00000006
6 0 1 0000000000000000 0 0 3 0 5a5a5a5a00000007
6 1 1 5a5a5a5a0000000a 0 0 3 0 5a5a5a5a00000008
6 0 1 0000000000000000 0 0 2 0 5a5a5a5a00000009
6 1 0 5a5a5a5a0000000b 0 0 3 0 5a5a5a5a00000009
6 0 1 0000000000000000 0 0 2 0 5a5a5a5a0000000a
6 0 1 0000000000000000 0 0 1 0 5a5a5a5a0000000b
6 1 1 5a5a5a5a0000000c 0 0 1 0 5a5a5a5a0000000c
6 0 1 0000000000000000 1 0 0 0 0000000000000000
6 0 0 0000000000000000 1 0 0 0 0000000000000000

//--- vlog.f
rtl/wbuf_pkg.sv
rtl/wbuf_capture.sv
rtl/wbuf_ctrl.sv
rtl/wbuf_store.sv
rtl/wbuf_top.sv
dv/wbuf_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the write buffer testbench with Verilator and run it from the project root
rm -f sim.log
verilator --binary --assert -Wno-fatal -f vlog.f --top-module wbuf_tb -o wbuf_sim \
   && ./obj_dir/wbuf_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"
exit 0
